//--- source/adc_acq_params.svh
`ifndef ADC_ACQ_PARAMS_SVH
`define ADC_ACQ_PARAMS_SVH

////////////////////////////////////////////////////////////
// sizes

`define CBUF_ADDR_W     8       // 256 sample pairs in the circular buffer
`define TRIG_FIFO_DEPTH 4       // queued trigger addresses
`define SAMPLE_W        12      // adc sample, over-range bit not counted

////////////////////////////////////////////////////////////
// record word tags, top nibble of every output word

`define TAG_HDR         4'd1    // waveform header
`define TAG_DAT         4'd2    // four sample pairs
`define TAG_SUM         4'd3    // xor checksum of the data words

`endif

//--- source/adc_acq_pkg.sv
`include "adc_acq_params.svh"

package adc_acq_pkg;

    // two samples per adc_clk, first one in the low bits
    typedef struct packed {
        logic [`SAMPLE_W-1:0] smp_b;    // second sample
        logic                 ovr_b;    // second over-range
        logic [`SAMPLE_W-1:0] smp_a;    // first sample
        logic                 ovr_a;    // first over-range
    } sample_pair_t;

    // waveform header view of a payload, channel_tag in the lsbs
    typedef struct packed {
        logic [45:0] pad;               // always zero
        logic [15:0] trig_addr;         // buffer address, zero-extended
        logic [15:0] pre_trig;
        logic [13:0] num_bursts;
        logic [23:0] fill_num;
        logic [11:0] channel_tag;
    } wfm_header_t;

    // four consecutive pairs, oldest in slot 0
    typedef sample_pair_t [3:0] burst_t;

    // one 128-bit payload read either as a header or as sample data
    typedef union packed {
        wfm_header_t hdr;
        struct packed {
            logic [23:0] pad;           // zero above the 104 data bits
            burst_t      pairs;
        } dat;
    } payload_u;

    typedef struct packed {
        logic [3:0] tag;                // TAG_HDR / TAG_DAT / TAG_SUM
        payload_u   payload;
    } acq_word_t;

    // reader -> formatter, strobes are mutually exclusive
    typedef struct packed {
        logic                    hdr_strobe;
        logic                    dat_strobe;
        logic                    sum_strobe;
        burst_t                  burst;     // valid with dat_strobe
        logic [`CBUF_ADDR_W-1:0] trig_addr; // valid for the whole record
    } reader_ctl_t;

endpackage

//--- source/cbuf_writer.sv
`include "adc_acq_params.svh"

module cbuf_writer (
    input  logic                      adc_clk,
    input  logic                      reset,
    input  logic                      acq_enable,   // capture while high
    input  logic                      acq_trig,     // rising edge marks a trigger
    input  adc_acq_pkg::sample_pair_t adc_pair,
    output logic                      wr_en,
    output logic [`CBUF_ADDR_W-1:0]   wr_addr,
    output adc_acq_pkg::sample_pair_t wr_data,
    output logic                      fifo_push,    // one cycle per accepted trigger
    output logic [`CBUF_ADDR_W-1:0]   trig_addr
);

    logic trig_q;       // acq_trig one cycle back
    logic trig_rise;

    assign trig_rise = acq_trig & ~trig_q;

    always_ff @(posedge adc_clk) begin
        if (reset) begin
            wr_en     <= 1'b0;
            wr_addr   <= '0;
            trig_q    <= 1'b0;
            fifo_push <= 1'b0;
        end else begin
            wr_en     <= acq_enable;
            trig_q    <= acq_trig;
            fifo_push <= trig_rise & wr_en & acq_enable;   // only into live data
            if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;  // wraps around the buffer
            end
        end
    end

    // pair sampled now is written next edge, at wr_addr + 1
    always_ff @(posedge adc_clk) begin
        wr_data   <= adc_pair;
        trig_addr <= wr_addr + 1'b1;
    end

    // pushed address is the slot of the pair seen with the trigger edge
    assert property (@(posedge adc_clk) disable iff (reset)
        fifo_push |-> wr_en && (trig_addr == wr_addr));

endmodule

//--- source/circular_buffer.sv
`include "adc_acq_params.svh"

module circular_buffer (
    input  logic                      adc_clk,
    input  logic                      wr_en,
    input  logic [`CBUF_ADDR_W-1:0]   wr_addr,
    input  adc_acq_pkg::sample_pair_t wr_data,
    input  logic [`CBUF_ADDR_W-1:0]   rd_addr,
    output adc_acq_pkg::sample_pair_t rd_data     // one cycle after rd_addr
);

    localparam int DEPTH = 1 << `CBUF_ADDR_W;

    ////////////////////////////////////////////////////////////
    // simple dual-port ram, both ports on adc_clk

    adc_acq_pkg::sample_pair_t mem [DEPTH];

    always_ff @(posedge adc_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];    // old data on a same-address collision
    end

endmodule

//--- source/trig_addr_fifo.sv
`include "adc_acq_params.svh"

module trig_addr_fifo (
    input  logic                    adc_clk,
    input  logic                    reset,
    input  logic                    push,
    input  logic [`CBUF_ADDR_W-1:0] push_addr,
    input  logic                    pop,        // one-cycle pulse, head already used
    output logic [`CBUF_ADDR_W-1:0] head_addr,  // valid while not empty
    output logic                    empty,
    output logic                    full
);

    localparam int PTR_W = $clog2(`TRIG_FIFO_DEPTH);

    logic [`CBUF_ADDR_W-1:0] mem [`TRIG_FIFO_DEPTH];
    logic [PTR_W:0]          wr_ptr;    // extra msb tells full from empty
    logic [PTR_W:0]          rd_ptr;

    assign empty     = (wr_ptr == rd_ptr);
    assign full      = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                       (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign head_addr = mem[rd_ptr[PTR_W-1:0]];  // fall-through

    always_ff @(posedge adc_clk) begin
        if (push && !full) begin
            mem[wr_ptr[PTR_W-1:0]] <= push_addr;
        end
    end

    always_ff @(posedge adc_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;    // push into a full queue is lost
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // reader only pops an entry it has seen
    assert property (@(posedge adc_clk) disable iff (reset) pop |-> !empty);

endmodule

//--- source/waveform_reader.sv
`include "adc_acq_params.svh"

module waveform_reader (
    input  logic                      adc_clk,
    input  logic                      reset,
    input  logic                      fifo_empty,
    input  logic [`CBUF_ADDR_W-1:0]   head_addr,
    input  logic [15:0]               pre_trig,     // pairs before the trigger
    input  logic [13:0]               num_bursts,   // bursts of four pairs
    input  adc_acq_pkg::sample_pair_t rd_data,
    output logic                      fifo_pop,
    output logic [`CBUF_ADDR_W-1:0]   rd_addr,
    output adc_acq_pkg::reader_ctl_t  rd_ctl
);

    typedef enum logic [1:0] {IDLE, LOAD, READ, FINISH} state_t;

    state_t                  state;
    logic [`CBUF_ADDR_W-1:0] trig_addr_q;   // popped trigger address
    logic [13:0]             bursts_left;   // bursts still to request
    logic [1:0]              pair_cnt;      // pair within the burst
    logic                    rd_vld;        // rd_data is a requested pair
    logic                    rd_last;       // ... and the 4th of its burst
    adc_acq_pkg::burst_t     shreg;
    logic                    hdr_strobe;
    logic                    dat_strobe;
    logic                    sum_strobe;

    assign fifo_pop = (state == IDLE) && !fifo_empty;

    ////////////////////////////////////////////////////////////
    // readout fsm

    always_ff @(posedge adc_clk) begin
        if (reset) begin
            state       <= IDLE;
            bursts_left <= '0;
            pair_cnt    <= '0;
            hdr_strobe  <= 1'b0;
            sum_strobe  <= 1'b0;
        end else begin
            hdr_strobe <= 1'b0;
            sum_strobe <= 1'b0;
            case (state)
                IDLE: begin
                    if (!fifo_empty) begin
                        state <= LOAD;      // pop happens this cycle
                    end
                end
                LOAD: begin
                    bursts_left <= num_bursts;
                    pair_cnt    <= '0;
                    hdr_strobe  <= 1'b1;
                    state       <= READ;
                end
                READ: begin
                    pair_cnt <= pair_cnt + 1'b1;
                    if (pair_cnt == 2'd3) begin
                        bursts_left <= bursts_left - 1'b1;
                        if (bursts_left == 14'd1) begin
                            state <= FINISH;    // last address issued
                        end
                    end
                end
                FINISH: begin
                    if (dat_strobe) begin       // final burst handed over
                        sum_strobe <= 1'b1;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ram return tracking, one cycle behind the address
    always_ff @(posedge adc_clk) begin
        if (reset) begin
            rd_vld     <= 1'b0;
            rd_last    <= 1'b0;
            dat_strobe <= 1'b0;
        end else begin
            rd_vld     <= (state == READ);
            rd_last    <= (state == READ) && (pair_cnt == 2'd3);
            dat_strobe <= rd_vld && rd_last;
        end
    end

    ////////////////////////////////////////////////////////////
    // address counter and burst assembly

    always_ff @(posedge adc_clk) begin
        if (fifo_pop) begin
            trig_addr_q <= head_addr;
        end
        if (state == LOAD) begin
            rd_addr <= trig_addr_q - pre_trig[`CBUF_ADDR_W-1:0];   // wraps
        end else if (state == READ) begin
            rd_addr <= rd_addr + 1'b1;
        end
        if (rd_vld) begin
            shreg <= {rd_data, shreg[3:1]};     // newest in at the top
        end
    end

    always_comb begin
        rd_ctl.hdr_strobe = hdr_strobe;
        rd_ctl.dat_strobe = dat_strobe;
        rd_ctl.sum_strobe = sum_strobe;
        rd_ctl.burst      = shreg;
        rd_ctl.trig_addr  = trig_addr_q;
    end

    // formatter sees one word kind per cycle
    assert property (@(posedge adc_clk) disable iff (reset)
        $onehot0({hdr_strobe, dat_strobe, sum_strobe}));

endmodule

//--- source/record_formatter.sv
`include "adc_acq_params.svh"

module record_formatter (
    input  logic                     adc_clk,
    input  logic                     reset,
    input  adc_acq_pkg::reader_ctl_t rd_ctl,
    input  logic [11:0]              channel_tag,
    input  logic [15:0]              pre_trig,
    input  logic [13:0]              num_bursts,
    input  logic [23:0]              initial_fill_num,
    input  logic                     fill_num_wr,   // load strobe
    output adc_acq_pkg::acq_word_t   acq_word,
    output logic                     acq_valid,     // sink takes every valid word
    output logic                     acq_done,      // with the checksum word
    output logic [23:0]              fill_num
);

    adc_acq_pkg::payload_u hdr_pl;  // header view
    adc_acq_pkg::payload_u dat_pl;  // data view
    adc_acq_pkg::payload_u csum;    // running xor of data payloads

    always_comb begin
        hdr_pl                 = '0;
        hdr_pl.hdr.channel_tag = channel_tag;
        hdr_pl.hdr.fill_num    = fill_num;
        hdr_pl.hdr.num_bursts  = num_bursts;
        hdr_pl.hdr.pre_trig    = pre_trig;
        hdr_pl.hdr.trig_addr   = {{(16-`CBUF_ADDR_W){1'b0}}, rd_ctl.trig_addr};
        dat_pl                 = '0;
        dat_pl.dat.pairs       = rd_ctl.burst;
    end

    ////////////////////////////////////////////////////////////
    // output word, one cycle after the reader strobe

    always_ff @(posedge adc_clk) begin
        if (rd_ctl.hdr_strobe) begin
            acq_word.tag     <= `TAG_HDR;
            acq_word.payload <= hdr_pl;
            csum             <= '0;     // new record
        end else if (rd_ctl.dat_strobe) begin
            acq_word.tag     <= `TAG_DAT;
            acq_word.payload <= dat_pl;
            csum             <= csum ^ dat_pl;
        end else if (rd_ctl.sum_strobe) begin
            acq_word.tag     <= `TAG_SUM;
            acq_word.payload <= csum;
        end
    end

    always_ff @(posedge adc_clk) begin
        if (reset) begin
            acq_valid <= 1'b0;
            acq_done  <= 1'b0;
            fill_num  <= '0;
        end else begin
            acq_valid <= rd_ctl.hdr_strobe | rd_ctl.dat_strobe | rd_ctl.sum_strobe;
            acq_done  <= rd_ctl.sum_strobe;
            if (fill_num_wr) begin
                fill_num <= initial_fill_num;   // load wins over advance
            end else if (rd_ctl.sum_strobe) begin
                fill_num <= fill_num + 24'd1;   // next record
            end
        end
    end

endmodule

//--- source/adc_acq_top.sv
`include "adc_acq_params.svh"

module adc_acq_top (
    input  logic                      adc_clk,
    input  logic                      reset,
    input  adc_acq_pkg::sample_pair_t adc_pair,
    input  logic                      acq_enable,
    input  logic                      acq_trig,
    input  logic [11:0]               channel_tag,
    input  logic [15:0]               pre_trig,
    input  logic [13:0]               num_bursts,
    input  logic [23:0]               initial_fill_num,
    input  logic                      fill_num_wr,
    output adc_acq_pkg::acq_word_t    adc_acq_out_dat,
    output logic                      adc_acq_out_valid,
    output logic                      acq_done,
    output logic [23:0]               fill_num
);

    logic                      wr_en;
    logic [`CBUF_ADDR_W-1:0]   wr_addr;
    adc_acq_pkg::sample_pair_t wr_data;
    logic                      fifo_push;
    logic [`CBUF_ADDR_W-1:0]   push_addr;   // write address at the trigger
    logic [`CBUF_ADDR_W-1:0]   head_addr;
    logic                      fifo_empty;
    logic                      fifo_pop;
    logic [`CBUF_ADDR_W-1:0]   rd_addr;
    adc_acq_pkg::sample_pair_t rd_data;
    adc_acq_pkg::reader_ctl_t  rd_ctl;

    ////////////////////////////////////////////////////////////
    // capture side

    cbuf_writer writer_inst (
        .adc_clk    (adc_clk),
        .reset      (reset),
        .acq_enable (acq_enable),
        .acq_trig   (acq_trig),
        .adc_pair   (adc_pair),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .fifo_push  (fifo_push),
        .trig_addr  (push_addr)
    );

    circular_buffer cbuf_inst (
        .adc_clk (adc_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    trig_addr_fifo fifo_inst (
        .adc_clk   (adc_clk),
        .reset     (reset),
        .push      (fifo_push),
        .push_addr (push_addr),
        .pop       (fifo_pop),
        .head_addr (head_addr),
        .empty     (fifo_empty),
        .full      ()               // overflow drop handled inside
    );

    ////////////////////////////////////////////////////////////
    // readout side

    waveform_reader reader_inst (
        .adc_clk    (adc_clk),
        .reset      (reset),
        .fifo_empty (fifo_empty),
        .head_addr  (head_addr),
        .pre_trig   (pre_trig),
        .num_bursts (num_bursts),
        .rd_data    (rd_data),
        .fifo_pop   (fifo_pop),
        .rd_addr    (rd_addr),
        .rd_ctl     (rd_ctl)
    );

    record_formatter formatter_inst (
        .adc_clk          (adc_clk),
        .reset            (reset),
        .rd_ctl           (rd_ctl),
        .channel_tag      (channel_tag),
        .pre_trig         (pre_trig),
        .num_bursts       (num_bursts),
        .initial_fill_num (initial_fill_num),
        .fill_num_wr      (fill_num_wr),
        .acq_word         (adc_acq_out_dat),
        .acq_valid        (adc_acq_out_valid),
        .acq_done         (acq_done),
        .fill_num         (fill_num)
    );

endmodule

//--- tests/adc_acq_tb.sv
module adc_acq_tb;

    localparam int          NUM_ROWS   = 5;
    localparam int          HIST_SIZE  = 1024;          // four buffer turns of pairs
    localparam logic [23:0] FILL_START = 24'h3a5c01;

    // one stimulus row, with the fill number its first header must carry
    typedef struct packed {
        logic [15:0] pre_trig;
        logic [13:0] num_bursts;
        logic [11:0] channel_tag;
        logic [7:0]  idle_cycles;   // before the first trigger
        logic        second_trig;   // queue a second trigger during readout
        logic [23:0] exp_fill;
    } row_t;

    logic                      adc_clk;
    logic                      reset;
    adc_acq_pkg::sample_pair_t adc_pair;
    logic                      acq_enable;
    logic                      acq_trig;
    logic [11:0]               channel_tag;
    logic [15:0]               pre_trig;
    logic [13:0]               num_bursts;
    logic [23:0]               initial_fill_num;
    logic                      fill_num_wr;
    adc_acq_pkg::acq_word_t    adc_acq_out_dat;
    logic                      adc_acq_out_valid;
    logic                      acq_done;
    logic [23:0]               fill_num;

    logic                      run_capture;     // starts the sample stream
    logic [31:0]               rng_state;
    int                        wr_count;        // pairs driven since enable
    logic [25:0]               history [HIST_SIZE];
    adc_acq_pkg::acq_word_t    words [$];       // every valid output word
    logic                      done_flags [$];  // acq_done seen with that word
    int                        done_count;
    row_t                      rows [NUM_ROWS];
    string                     row_names [NUM_ROWS];

    adc_acq_top adc_acq_top_inst (
        .adc_clk           (adc_clk),
        .reset             (reset),
        .adc_pair          (adc_pair),
        .acq_enable        (acq_enable),
        .acq_trig          (acq_trig),
        .channel_tag       (channel_tag),
        .pre_trig          (pre_trig),
        .num_bursts        (num_bursts),
        .initial_fill_num  (initial_fill_num),
        .fill_num_wr       (fill_num_wr),
        .adc_acq_out_dat   (adc_acq_out_dat),
        .adc_acq_out_valid (adc_acq_out_valid),
        .acq_done          (acq_done),
        .fill_num          (fill_num)
    );

    initial adc_clk = 1'b0;
    always #10 adc_clk = ~adc_clk;      // period 20

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////////////////////////
    // sample source and output monitor

    // pair driven with count n lands at buffer address n mod 256
    always @(posedge adc_clk) begin
        if (run_capture) begin
            rng_state = xorshift32(rng_state);
            acq_enable                    <= 1'b1;
            adc_pair                      <= rng_state[25:0];
            history[wr_count % HIST_SIZE] <= rng_state[25:0];
            wr_count                      <= wr_count + 1;
        end
    end

    always @(negedge adc_clk) begin
        if (!reset) begin
            if (adc_acq_out_valid) begin
                words.push_back(adc_acq_out_dat);
                done_flags.push_back(acq_done);
            end
            if (acq_done) begin
                done_count = done_count + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expect_equal(input string what, input logic [131:0] exp,
                                input logic [131:0] act);
        if (act !== exp) begin
            abort_run($sformatf("MISMATCH %s expected %0h actual %0h", what, exp, act));
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge adc_clk);
    endtask

    task automatic wait_for_words(input int need, input int limit, input string what);
        int n;
        n = 0;
        while (words.size() < need && n < limit) begin
            @(posedge adc_clk);
            n++;
        end
        if (words.size() < need) begin
            abort_run($sformatf("timeout: %s gave %0d of %0d words in %0d cycles",
                                what, words.size(), need, limit));
        end
    endtask

    // count of the pair driven on the same edge is the trigger address
    task automatic fire_trigger(output int at_count);
        @(posedge adc_clk);
        at_count = wr_count;
        acq_trig <= 1'b1;
        @(posedge adc_clk);
        acq_trig <= 1'b0;
    endtask

    // header, num_bursts data words, checksum, all from the head of the queue
    task automatic check_record(input string name, input int trig, input row_t row,
                                input logic [23:0] fill);
        adc_acq_pkg::acq_word_t w;
        logic                   d;
        logic [127:0]           exp_pl;
        logic [127:0]           sum;
        int                     base;
        int                     k;
        w = words.pop_front();
        d = done_flags.pop_front();
        expect_equal($sformatf("%s header tag", name), 4'd1, w.tag);
        expect_equal($sformatf("%s channel_tag", name), row.channel_tag,
                     w.payload.hdr.channel_tag);
        expect_equal($sformatf("%s fill_num", name), fill, w.payload.hdr.fill_num);
        expect_equal($sformatf("%s num_bursts", name), row.num_bursts,
                     w.payload.hdr.num_bursts);
        expect_equal($sformatf("%s pre_trig", name), row.pre_trig, w.payload.hdr.pre_trig);
        expect_equal($sformatf("%s trig_addr", name), trig % 256, w.payload.hdr.trig_addr);
        expect_equal($sformatf("%s header pad", name), 0, w.payload.hdr.pad);
        expect_equal($sformatf("%s header done", name), 0, d);
        sum  = '0;
        base = trig - int'(row.pre_trig);   // window start, as a pair count
        for (k = 0; k < int'(row.num_bursts); k++) begin
            w = words.pop_front();
            d = done_flags.pop_front();
            exp_pl = {24'h0,
                      history[(base + 4*k + 3) % HIST_SIZE],
                      history[(base + 4*k + 2) % HIST_SIZE],
                      history[(base + 4*k + 1) % HIST_SIZE],
                      history[(base + 4*k)     % HIST_SIZE]};   // oldest in slot 0
            sum = sum ^ exp_pl;
            expect_equal($sformatf("%s data %0d tag", name, k), 4'd2, w.tag);
            expect_equal($sformatf("%s data %0d payload", name, k), exp_pl, w.payload);
            expect_equal($sformatf("%s data %0d done", name, k), 0, d);
        end
        w = words.pop_front();
        d = done_flags.pop_front();
        expect_equal($sformatf("%s checksum tag", name), 4'd3, w.tag);
        expect_equal($sformatf("%s checksum", name), sum, w.payload);
        expect_equal($sformatf("%s checksum done", name), 1, d);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        row_t row;
        int   trig_cnt [2];
        int   records;
        int   done_exp;
        int   r;
        int   i;

        reset            = 1'b1;
        adc_pair         = '0;
        acq_enable       = 1'b0;
        acq_trig         = 1'b0;
        channel_tag      = '0;
        pre_trig         = 16'd8;
        num_bursts       = 14'd1;
        initial_fill_num = '0;
        fill_num_wr      = 1'b0;
        run_capture      = 1'b0;
        rng_state        = 32'd44;   // xorshift seed
        wr_count         = 0;
        done_count       = 0;
        done_exp         = 0;

        //            pre     bursts  chan     idle   2nd   first fill
        rows[0] = '{16'd8,   14'd1,  12'h101, 8'd20, 1'b0, FILL_START};
        rows[1] = '{16'd16,  14'd4,  12'h2b2, 8'd12, 1'b0, FILL_START + 24'd1};
        rows[2] = '{16'd24,  14'd6,  12'h3c3, 8'd30, 1'b1, FILL_START + 24'd2};
        rows[3] = '{16'd100, 14'd30, 12'h4d4, 8'd5,  1'b0, FILL_START + 24'd4};
        rows[4] = '{16'd200, 14'd13, 12'h5e5, 8'd40, 1'b1, FILL_START + 24'd5};
        row_names[0] = "single_burst";
        row_names[1] = "four_bursts";
        row_names[2] = "queued_pair";
        row_names[3] = "long_window";
        row_names[4] = "deep_pretrig";

        repeat (8) @(posedge adc_clk);
        reset       <= 1'b0;
        run_capture <= 1'b1;

        // no output before any trigger, buffer filled past the deepest window
        idle(300);
        expect_equal("reset valid words", 0, words.size());
        expect_equal("reset done pulses", 0, done_count);
        @(negedge adc_clk);
        expect_equal("reset fill_num", 0, fill_num);

        @(posedge adc_clk);
        initial_fill_num <= FILL_START;
        fill_num_wr      <= 1'b1;
        @(posedge adc_clk);
        fill_num_wr      <= 1'b0;
        @(negedge adc_clk);
        expect_equal("fill_num load", FILL_START, fill_num);

        for (r = 0; r < NUM_ROWS; r++) begin
            row     = rows[r];
            records = row.second_trig ? 2 : 1;
            @(posedge adc_clk);
            channel_tag <= row.channel_tag;     // held until the row is done
            pre_trig    <= row.pre_trig;
            num_bursts  <= row.num_bursts;
            idle(int'(row.idle_cycles));
            fire_trigger(trig_cnt[0]);
            if (row.second_trig) begin
                idle(6);    // first window still being read
                fire_trigger(trig_cnt[1]);
            end
            wait_for_words(records * (int'(row.num_bursts) + 2),
                           records * (4 * int'(row.num_bursts) + 40), row_names[r]);
            for (i = 0; i < records; i++) begin
                check_record($sformatf("%s rec %0d", row_names[r], i), trig_cnt[i], row,
                             row.exp_fill + 24'(i));
            end
            done_exp = done_exp + records;
            idle(12);   // nothing trails the last checksum
            expect_equal($sformatf("%s extra words", row_names[r]), 0, words.size());
            expect_equal($sformatf("%s done pulses", row_names[r]), done_exp, done_count);
            @(negedge adc_clk);
            expect_equal($sformatf("%s fill_num after", row_names[r]),
                         row.exp_fill + 24'(records), fill_num);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- adc_acq_top.f
+incdir+source
source/adc_acq_pkg.sv
source/cbuf_writer.sv
source/circular_buffer.sv
source/trig_addr_fifo.sv
source/waveform_reader.sv
source/record_formatter.sv
source/adc_acq_top.sv
tests/adc_acq_tb.sv

//--- Makefile
TOP := adc_acq_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f adc_acq_top.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
